/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_rv_core -f verilog.f \
    -o sim_rv_core > build.log 2>&1 \
    && ./obj_dir/sim_rv_core > sim.log 2>&1 ; cat sim.log 2>/dev/null
test -s sim.log \
    && ! grep -q "TEST RESULT: FAIL" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* rv_bus_master.sv */
`timescale 1ns/1ps

module rv_bus_master (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_req_valid,
    input  logic [rv_pkg::xlen-1:0] i_req_addr,
    input  logic                   i_ack,
    input  logic                   i_stall,
    input  logic [rv_pkg::xlen-1:0] i_data,
    output logic                   o_cyc,
    output logic                   o_stb,
    output logic [rv_pkg::xlen-1:0] o_addr,
    output logic                   o_rsp_valid,
    output logic [rv_pkg::xlen-1:0] o_rsp_data
);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_cyc <= 1'b0;
            o_stb <= 1'b0;
            o_rsp_valid <= 1'b0;
        end else begin
            o_rsp_valid <= 1'b0;
            if (i_req_valid) begin
                o_cyc <= 1'b1;
                o_stb <= 1'b1;
            end else if (o_cyc) begin
                // strobe held until the slave takes it
                if (o_stb && !i_stall) begin
                    o_stb <= 1'b0;
                end
                if (i_ack && !i_stall) begin
                    o_cyc <= 1'b0;
                    o_rsp_valid <= 1'b1;
                end
            end
        end
    end

    // address and read word
    always_ff @(posedge i_clk) begin
        if (i_req_valid) begin
            o_addr <= i_req_addr;
        end
        if (o_cyc && i_ack && !i_stall) begin
            o_rsp_data <= i_data;
        end
    end

endmodule

/* rv_cases.txt */
# m <byte address> <word> : memory image
# f <address> : expected bus cycle address, w <rd> <value> : expected register write
m 20400000 ffb00093
m 20400004 12345137
m 20400008 00001197
m 2040000c 0020a233
m 20400010 02400313
m 20400014 4060d2b3
m 20400018 0060d3b3
m 2040001c 00700013
m 20400020 00401463
m 20400028 00400463
m 2040002c 0000c463
m 20400034 0000f463
m 2040003c 0000e463
m 20400040 0000d463
m 20400044 00c0046f
m 20400050 011404e7
m 20400058 ff918503
m 2040005c ffb1c583
m 20400060 ffa19603
m 20400064 ff81d683
m 20400068 ff81a703
m 2040006c ff818783
m 20400070 00600833
m 20400074 401308b3
m 20400078 0000006f
m 20401000 80f17f82
f 20400000
w 01 fffffffb
f 20400004
w 02 12345000
f 20400008
w 03 20401008
f 2040000c
w 04 00000001
f 20400010
w 06 00000024
f 20400014
w 05 ffffffff
f 20400018
w 07 0fffffff
f 2040001c
w 00 00000007
f 20400020
f 20400028
f 2040002c
f 20400034
f 2040003c
f 20400040
f 20400044
w 08 20400048
f 20400050
w 09 20400054
f 20400058
f 20401001
w 0a 0000007f
f 2040005c
f 20401003
w 0b 00000080
f 20400060
f 20401002
w 0c ffff80f1
f 20400064
f 20401000
w 0d 00007f82
f 20400068
f 20401000
w 0e 80f17f82
f 2040006c
f 20401000
w 0f ffffff82
f 20400070
w 10 00000024
f 20400074
w 11 00000029
f 20400078
w 00 2040007c
f 20400078

/* rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
    parameter logic [31:0] p_pc_start = 32'h20400000
) (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_ack,
    input  logic                         i_stall,
    input  logic [rv_pkg::xlen-1:0]       i_data,
    output logic                         o_cyc,
    output logic                         o_stb,
    output logic [rv_pkg::xlen-1:0]       o_addr,
    output logic                         o_rd_we,
    output logic [rv_pkg::reg_addr_w-1:0] o_rd_addr,
    output logic [rv_pkg::xlen-1:0]       o_rd_data
);

    logic req_valid;
    logic [rv_pkg::xlen-1:0] req_addr;
    logic rsp_valid;
    logic [rv_pkg::xlen-1:0] rsp_data;
    logic dec_load;
    logic [rv_pkg::xlen-1:0] dec_word;
    logic exe_start;
    logic ld_done;
    logic [rv_pkg::xlen-1:0] pc;
    logic pc_load;
    logic [rv_pkg::xlen-1:0] pc_target;
    logic [rv_pkg::xlen-1:0] load_addr;

    logic [rv_pkg::alu_op_w-1:0] alu_op;
    logic use_imm;
    logic is_load;
    logic is_branch;
    logic is_jal;
    logic is_jalr;
    logic is_auipc;
    logic writes_rd;
    logic [2:0] funct3;
    logic [rv_pkg::reg_addr_w-1:0] rd;
    logic [rv_pkg::reg_addr_w-1:0] rs1;
    logic [rv_pkg::reg_addr_w-1:0] rs2;
    logic [rv_pkg::xlen-1:0] imm;

    rv_bus_master bus_master_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_req_valid (req_valid),
        .i_req_addr  (req_addr),
        .i_ack       (i_ack),
        .i_stall     (i_stall),
        .i_data      (i_data),
        .o_cyc       (o_cyc),
        .o_stb       (o_stb),
        .o_addr      (o_addr),
        .o_rsp_valid (rsp_valid),
        .o_rsp_data  (rsp_data)
    );

    rv_sequencer #(
        .p_pc_start (p_pc_start)
    ) sequencer_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_rsp_valid (rsp_valid),
        .i_rsp_data  (rsp_data),
        .i_is_load   (is_load),
        .i_pc_load   (pc_load),
        .i_pc_target (pc_target),
        .i_load_addr (load_addr),
        .o_req_valid (req_valid),
        .o_req_addr  (req_addr),
        .o_dec_load  (dec_load),
        .o_dec_word  (dec_word),
        .o_exe_start (exe_start),
        .o_ld_done   (ld_done),
        .o_pc        (pc)
    );

    rv_decoder decoder_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_dec_load  (dec_load),
        .i_word      (dec_word),
        .o_alu_op    (alu_op),
        .o_use_imm   (use_imm),
        .o_is_load   (is_load),
        .o_is_branch (is_branch),
        .o_is_jal    (is_jal),
        .o_is_jalr   (is_jalr),
        .o_is_auipc  (is_auipc),
        .o_writes_rd (writes_rd),
        .o_funct3    (funct3),
        .o_rd        (rd),
        .o_rs1       (rs1),
        .o_rs2       (rs2),
        .o_imm       (imm)
    );

    rv_execute execute_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_exe_start (exe_start),
        .i_ld_done   (ld_done),
        .i_pc        (pc),
        .i_rsp_data  (rsp_data),
        .i_alu_op    (alu_op),
        .i_use_imm   (use_imm),
        .i_is_load   (is_load),
        .i_is_branch (is_branch),
        .i_is_jal    (is_jal),
        .i_is_jalr   (is_jalr),
        .i_is_auipc  (is_auipc),
        .i_writes_rd (writes_rd),
        .i_funct3    (funct3),
        .i_rd        (rd),
        .i_rs1       (rs1),
        .i_rs2       (rs2),
        .i_imm       (imm),
        .o_pc_load   (pc_load),
        .o_pc_target (pc_target),
        .o_load_addr (load_addr),
        .o_rd_we     (o_rd_we),
        .o_rd_addr   (o_rd_addr),
        .o_rd_data   (o_rd_data)
    );

endmodule

/* rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_dec_load,
    input  logic [rv_pkg::xlen-1:0]       i_word,
    output logic [rv_pkg::alu_op_w-1:0]   o_alu_op,
    output logic                         o_use_imm,
    output logic                         o_is_load,
    output logic                         o_is_branch,
    output logic                         o_is_jal,
    output logic                         o_is_jalr,
    output logic                         o_is_auipc,
    output logic                         o_writes_rd,
    output logic [2:0]                   o_funct3,
    output logic [rv_pkg::reg_addr_w-1:0] o_rd,
    output logic [rv_pkg::reg_addr_w-1:0] o_rs1,
    output logic [rv_pkg::reg_addr_w-1:0] o_rs2,
    output logic [rv_pkg::xlen-1:0]       o_imm
);

    rv_pkg::rv_instr_u ins;
    logic [6:0] opcode;
    logic is_alu;
    logic [rv_pkg::xlen-1:0] imm_next;
    logic [rv_pkg::alu_op_w-1:0] alu_next;

    assign ins = i_word;
    assign opcode = ins.r_fmt.opcode;
    assign is_alu = (opcode == rv_pkg::op_alu_imm) || (opcode == rv_pkg::op_alu_reg);

    always_comb begin
        case (opcode)
            rv_pkg::op_branch:
                imm_next = {{19{ins.b_fmt.imm12}}, ins.b_fmt.imm12, ins.b_fmt.imm11,
                            ins.b_fmt.imm10_5, ins.b_fmt.imm4_1, 1'b0};
            rv_pkg::op_lui, rv_pkg::op_auipc:
                imm_next = {ins.u_fmt.imm, 12'b0};
            rv_pkg::op_jal:
                imm_next = {{11{ins.j_fmt.imm20}}, ins.j_fmt.imm20, ins.j_fmt.imm19_12,
                            ins.j_fmt.imm11, ins.j_fmt.imm10_1, 1'b0};
            default:
                imm_next = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
        endcase
    end

    always_comb begin
        alu_next = rv_pkg::alu_add;
        if (opcode == rv_pkg::op_lui) begin
            alu_next = rv_pkg::alu_pass_b;
        end else if (is_alu) begin
            case (ins.r_fmt.funct3)
                // addi has no sub form
                3'b000: alu_next = (opcode == rv_pkg::op_alu_reg && ins.r_fmt.funct7[5]) ?
                                   rv_pkg::alu_sub : rv_pkg::alu_add;
                3'b001: alu_next = rv_pkg::alu_sll;
                3'b010: alu_next = rv_pkg::alu_slt;
                3'b011: alu_next = rv_pkg::alu_sltu;
                3'b100: alu_next = rv_pkg::alu_xor;
                3'b101: alu_next = ins.r_fmt.funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                3'b110: alu_next = rv_pkg::alu_or;
                default: alu_next = rv_pkg::alu_and;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_use_imm <= 1'b0;
            o_is_load <= 1'b0;
            o_is_branch <= 1'b0;
            o_is_jal <= 1'b0;
            o_is_jalr <= 1'b0;
            o_is_auipc <= 1'b0;
            o_writes_rd <= 1'b0;
        end else if (i_dec_load) begin
            o_use_imm <= (opcode == rv_pkg::op_alu_imm) || (opcode == rv_pkg::op_load) ||
                         (opcode == rv_pkg::op_jalr) || (opcode == rv_pkg::op_lui);
            o_is_load <= (opcode == rv_pkg::op_load);
            o_is_branch <= (opcode == rv_pkg::op_branch);
            o_is_jal <= (opcode == rv_pkg::op_jal);
            o_is_jalr <= (opcode == rv_pkg::op_jalr);
            o_is_auipc <= (opcode == rv_pkg::op_auipc);
            // unknown opcodes write nothing
            o_writes_rd <= is_alu || (opcode == rv_pkg::op_lui) ||
                           (opcode == rv_pkg::op_auipc) || (opcode == rv_pkg::op_jal) ||
                           (opcode == rv_pkg::op_jalr);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_dec_load) begin
            o_alu_op <= alu_next;
            o_funct3 <= ins.r_fmt.funct3;
            o_rd <= ins.r_fmt.rd;
            o_rs1 <= ins.r_fmt.rs1;
            o_rs2 <= ins.r_fmt.rs2;
            o_imm <= imm_next;
        end
    end

endmodule

/* rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_exe_start,
    input  logic                         i_ld_done,
    input  logic [rv_pkg::xlen-1:0]       i_pc,
    input  logic [rv_pkg::xlen-1:0]       i_rsp_data,
    input  logic [rv_pkg::alu_op_w-1:0]   i_alu_op,
    input  logic                         i_use_imm,
    input  logic                         i_is_load,
    input  logic                         i_is_branch,
    input  logic                         i_is_jal,
    input  logic                         i_is_jalr,
    input  logic                         i_is_auipc,
    input  logic                         i_writes_rd,
    input  logic [2:0]                   i_funct3,
    input  logic [rv_pkg::reg_addr_w-1:0] i_rd,
    input  logic [rv_pkg::reg_addr_w-1:0] i_rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] i_rs2,
    input  logic [rv_pkg::xlen-1:0]       i_imm,
    output logic                         o_pc_load,
    output logic [rv_pkg::xlen-1:0]       o_pc_target,
    output logic [rv_pkg::xlen-1:0]       o_load_addr,
    output logic                         o_rd_we,
    output logic [rv_pkg::reg_addr_w-1:0] o_rd_addr,
    output logic [rv_pkg::xlen-1:0]       o_rd_data
);

    logic [rv_pkg::xlen-1:0] rs1_val;
    logic [rv_pkg::xlen-1:0] rs2_val;
    logic [rv_pkg::xlen-1:0] op_b;
    logic [rv_pkg::xlen-1:0] alu_res;
    logic [rv_pkg::xlen-1:0] exe_res;
    logic [4:0] shamt;
    logic lt_s;
    logic lt_u;
    logic taken;
    logic [1:0] ld_off;
    logic [2:0] ld_f3;
    logic [rv_pkg::reg_addr_w-1:0] ld_rd;
    logic [rv_pkg::xlen-1:0] ld_word;
    logic [rv_pkg::xlen-1:0] ld_data;

    rv_regfile regfile_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_we      (o_rd_we),
        .i_waddr   (o_rd_addr),
        .i_wdata   (o_rd_data),
        .i_raddr_a (i_rs1),
        .i_raddr_b (i_rs2),
        .o_rdata_a (rs1_val),
        .o_rdata_b (rs2_val)
    );

    assign op_b = i_use_imm ? i_imm : rs2_val;
    assign shamt = op_b[4:0];
    assign lt_s = $signed(rs1_val) < $signed(op_b);
    assign lt_u = rs1_val < op_b;

    always_comb begin
        case (i_alu_op)
            rv_pkg::alu_sub: alu_res = rs1_val - op_b;
            rv_pkg::alu_sll: alu_res = rs1_val << shamt;
            rv_pkg::alu_slt: alu_res = {{(rv_pkg::xlen-1){1'b0}}, lt_s};
            rv_pkg::alu_sltu: alu_res = {{(rv_pkg::xlen-1){1'b0}}, lt_u};
            rv_pkg::alu_xor: alu_res = rs1_val ^ op_b;
            rv_pkg::alu_srl: alu_res = rs1_val >> shamt;
            rv_pkg::alu_sra: alu_res = $signed(rs1_val) >>> shamt;
            rv_pkg::alu_or: alu_res = rs1_val | op_b;
            rv_pkg::alu_and: alu_res = rs1_val & op_b;
            rv_pkg::alu_pass_b: alu_res = op_b;
            default: alu_res = rs1_val + op_b;
        endcase
    end

    // branches always compare two registers, so op_b is rs2 here
    always_comb begin
        case (i_funct3)
            rv_pkg::f3_beq: taken = (rs1_val == op_b);
            rv_pkg::f3_bne: taken = (rs1_val != op_b);
            rv_pkg::f3_blt: taken = lt_s;
            rv_pkg::f3_bge: taken = !lt_s;
            rv_pkg::f3_bltu: taken = lt_u;
            rv_pkg::f3_bgeu: taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

    assign o_pc_load = i_exe_start && (i_is_jal || i_is_jalr || (i_is_branch && taken));
    assign o_pc_target = i_is_jalr ? {alu_res[rv_pkg::xlen-1:1], 1'b0} : i_pc + i_imm;
    assign o_load_addr = alu_res;

    always_comb begin
        if (i_is_jal || i_is_jalr) begin
            exe_res = i_pc + 32'd4;
        end else if (i_is_auipc) begin
            exe_res = i_pc + i_imm;
        end else begin
            exe_res = alu_res;
        end
    end

    // pending load is written back on ld_done
    always_ff @(posedge i_clk) begin
        if (i_exe_start && i_is_load) begin
            ld_off <= alu_res[1:0];
            ld_f3 <= i_funct3;
            ld_rd <= i_rd;
        end
    end

    assign ld_word = i_rsp_data >> {ld_off, 3'b000};

    always_comb begin
        case (ld_f3)
            rv_pkg::f3_lb: ld_data = {{24{ld_word[7]}}, ld_word[7:0]};
            rv_pkg::f3_lh: ld_data = {{16{ld_word[15]}}, ld_word[15:0]};
            rv_pkg::f3_lbu: ld_data = {24'b0, ld_word[7:0]};
            rv_pkg::f3_lhu: ld_data = {16'b0, ld_word[15:0]};
            default: ld_data = i_rsp_data;
        endcase
    end

    assign o_rd_we = (i_exe_start && i_writes_rd) || i_ld_done;
    assign o_rd_addr = i_ld_done ? ld_rd : i_rd;
    assign o_rd_data = i_ld_done ? ld_data : exe_res;

endmodule

/* rv_pkg.sv */
package rv_pkg;

    localparam int unsigned xlen = 32;
    localparam int unsigned reg_addr_w = 5;
    localparam int unsigned alu_op_w = 4;

    // major opcodes
    localparam logic [6:0] op_lui = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jal = 7'b1101111;
    localparam logic [6:0] op_jalr = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_alu_imm = 7'b0010011;
    localparam logic [6:0] op_alu_reg = 7'b0110011;
    localparam logic [6:0] op_load = 7'b0000011;

    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;
    localparam logic [2:0] f3_blt = 3'b100;
    localparam logic [2:0] f3_bge = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [2:0] f3_lb = 3'b000;
    localparam logic [2:0] f3_lh = 3'b001;
    localparam logic [2:0] f3_lw = 3'b010;
    localparam logic [2:0] f3_lbu = 3'b100;
    localparam logic [2:0] f3_lhu = 3'b101;

    localparam logic [alu_op_w-1:0] alu_add = 4'd0;
    localparam logic [alu_op_w-1:0] alu_sub = 4'd1;
    localparam logic [alu_op_w-1:0] alu_sll = 4'd2;
    localparam logic [alu_op_w-1:0] alu_slt = 4'd3;
    localparam logic [alu_op_w-1:0] alu_sltu = 4'd4;
    localparam logic [alu_op_w-1:0] alu_xor = 4'd5;
    localparam logic [alu_op_w-1:0] alu_srl = 4'd6;
    localparam logic [alu_op_w-1:0] alu_sra = 4'd7;
    localparam logic [alu_op_w-1:0] alu_or = 4'd8;
    localparam logic [alu_op_w-1:0] alu_and = 4'd9;
    // lui result is the immediate itself
    localparam logic [alu_op_w-1:0] alu_pass_b = 4'd10;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_i_fmt_t;

    typedef struct packed {
        logic imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic imm11;
        logic [6:0] opcode;
    } rv_b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_u_fmt_t;

    typedef struct packed {
        logic imm20;
        logic [9:0] imm10_1;
        logic imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_j_fmt_t;

    typedef union packed {
        rv_r_fmt_t r_fmt;
        rv_i_fmt_t i_fmt;
        rv_b_fmt_t b_fmt;
        rv_u_fmt_t u_fmt;
        rv_j_fmt_t j_fmt;
    } rv_instr_u;

endpackage

/* rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
    input  logic                         i_clk,
    input  logic                         i_rst,
    input  logic                         i_we,
    input  logic [rv_pkg::reg_addr_w-1:0] i_waddr,
    input  logic [rv_pkg::xlen-1:0]       i_wdata,
    input  logic [rv_pkg::reg_addr_w-1:0] i_raddr_a,
    input  logic [rv_pkg::reg_addr_w-1:0] i_raddr_b,
    output logic [rv_pkg::xlen-1:0]       o_rdata_a,
    output logic [rv_pkg::xlen-1:0]       o_rdata_b
);

    logic [rv_pkg::xlen-1:0] regs [32];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != '0)) begin
            // x0 never takes a write
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata_a = regs[i_raddr_a];
    assign o_rdata_b = regs[i_raddr_b];

endmodule

/* rv_sequencer.sv */
`timescale 1ns/1ps

module rv_sequencer #(
    parameter logic [31:0] p_pc_start = 32'h20400000
) (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_rsp_valid,
    input  logic [rv_pkg::xlen-1:0] i_rsp_data,
    input  logic                   i_is_load,
    input  logic                   i_pc_load,
    input  logic [rv_pkg::xlen-1:0] i_pc_target,
    input  logic [rv_pkg::xlen-1:0] i_load_addr,
    output logic                   o_req_valid,
    output logic [rv_pkg::xlen-1:0] o_req_addr,
    output logic                   o_dec_load,
    output logic [rv_pkg::xlen-1:0] o_dec_word,
    output logic                   o_exe_start,
    output logic                   o_ld_done,
    output logic [rv_pkg::xlen-1:0] o_pc
);

    localparam logic [2:0] s_fetch = 3'd0;
    localparam logic [2:0] s_fetch_wait = 3'd1;
    localparam logic [2:0] s_execute = 3'd2;
    localparam logic [2:0] s_access = 3'd3;
    localparam logic [2:0] s_load_wait = 3'd4;

    logic [2:0] state;
    logic [rv_pkg::xlen-1:0] pc;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= s_fetch;
            pc <= p_pc_start;
        end else begin
            case (state)
                s_fetch: state <= s_fetch_wait;
                s_fetch_wait: begin
                    // word goes to the decoder on this edge
                    if (i_rsp_valid) begin
                        state <= s_execute;
                    end
                end
                s_execute: begin
                    pc <= i_pc_load ? i_pc_target : pc + 32'd4;
                    state <= i_is_load ? s_access : s_fetch;
                end
                s_access: state <= s_load_wait;
                s_load_wait: begin
                    if (i_rsp_valid) begin
                        state <= s_fetch;
                    end
                end
                default: state <= s_fetch;
            endcase
        end
    end

    assign o_req_valid = (state == s_fetch) || (state == s_access);
    // load address stays valid while the decode outputs hold
    assign o_req_addr = (state == s_access) ? i_load_addr : pc;
    assign o_dec_load = (state == s_fetch_wait) && i_rsp_valid;
    assign o_dec_word = i_rsp_data;
    assign o_exe_start = (state == s_execute);
    assign o_ld_done = (state == s_load_wait) && i_rsp_valid;
    assign o_pc = pc;

endmodule

/* tb_rv_checker.sv */
`timescale 1ns/1ps

module tb_rv_checker #(
    parameter int p_max_events = 128
) (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_cyc,
    input  logic        i_stb,
    input  logic        i_stall,
    input  logic [31:0] i_addr,
    input  logic        i_rd_we,
    input  logic [4:0]  i_rd_addr,
    input  logic [31:0] i_rd_data,
    input  logic        i_ev_is_write [p_max_events],
    input  logic [31:0] i_ev_a [p_max_events],
    input  logic [31:0] i_ev_v [p_max_events],
    input  int          i_ev_count,
    output logic        o_done,
    output int          o_seen_cnt,
    output int          o_pass_cnt,
    output int          o_fail_cnt
);

    logic cyc_q = 1'b0;
    logic stb_q = 1'b0;
    logic stall_q = 1'b1;
    logic exp_stb;

    initial begin
        o_seen_cnt = 0;
        o_pass_cnt = 0;
        o_fail_cnt = 0;
    end

    assign o_done = (i_ev_count > 0) && (o_seen_cnt >= i_ev_count);

    task automatic check_fetch(input logic [31:0] addr);
        int idx;
        idx = o_seen_cnt;
        if (i_ev_is_write[idx]) begin
            $display("event %0d: a register write was expected, but a bus cycle to %h started",
                     idx, addr);
            o_fail_cnt++;
        end else if (addr !== i_ev_a[idx]) begin
            $display("Fail at %0t: o_addr expected %h got %h", $time, i_ev_a[idx], addr);
            o_fail_cnt++;
        end else begin
            $display("pass event %0d: bus cycle at %h", idx, addr);
            o_pass_cnt++;
        end
        o_seen_cnt++;
    endtask

    task automatic check_write(input logic [4:0] rd, input logic [31:0] data);
        int idx;
        idx = o_seen_cnt;
        if (!i_ev_is_write[idx]) begin
            $display("event %0d: a bus cycle to %h was expected, but x%0d was written",
                     idx, i_ev_a[idx], rd);
            o_fail_cnt++;
        end else if (rd !== i_ev_a[idx][4:0]) begin
            $display("Fail at %0t: o_rd_addr expected %0d got %0d", $time, i_ev_a[idx][4:0], rd);
            o_fail_cnt++;
        end else if (data !== i_ev_v[idx]) begin
            $display("Fail at %0t: o_rd_data expected %h got %h", $time, i_ev_v[idx], data);
            o_fail_cnt++;
        end else begin
            $display("pass event %0d: x%0d <= %h", idx, rd, data);
            o_pass_cnt++;
        end
        o_seen_cnt++;
    endtask

    // o_addr is valid from the edge that raises o_cyc
    always @(posedge i_clk) begin
        if (i_rst) begin
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
            stall_q <= 1'b1;
        end else begin
            if (i_cyc && !cyc_q && !o_done) begin
                check_fetch(i_addr);
            end
            if (i_rd_we && !o_done) begin
                check_write(i_rd_addr, i_rd_data);
            end
            // strobe rises with cyc and holds until a cycle without stall
            exp_stb = i_cyc && (!cyc_q || (stb_q && stall_q));
            if (i_stb !== exp_stb && !o_done) begin
                $display("Fail at %0t: o_stb expected %b got %b", $time, exp_stb, i_stb);
                o_fail_cnt++;
            end
            cyc_q <= i_cyc;
            stb_q <= i_stb;
            stall_q <= i_stall;
        end
    end

endmodule

/* tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

    localparam int max_events = 128;

    logic        i_clk;
    logic        i_rst;
    logic        i_ack;
    logic        i_stall;
    logic [31:0] i_data;
    logic        o_cyc;
    logic        o_stb;
    logic [31:0] o_addr;
    logic        o_rd_we;
    logic [4:0]  o_rd_addr;
    logic [31:0] o_rd_data;

    logic [31:0] mem [logic [31:0]];
    logic        ev_is_write [max_events];
    logic [31:0] ev_a [max_events];
    logic [31:0] ev_v [max_events];
    int          ev_count = 0;
    logic        loaded = 1'b0;
    logic        done;
    int          seen_cnt;
    int          pass_cnt;
    int          fail_cnt;

    logic [31:0] rnd = 32'h29e3;
    logic [31:0] req_addr;
    int          phase = 0;
    int          stall_left;
    int          ack_left;

    rv_core #(
        .p_pc_start (32'h20400000)
    ) dut_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_ack     (i_ack),
        .i_stall   (i_stall),
        .i_data    (i_data),
        .o_cyc     (o_cyc),
        .o_stb     (o_stb),
        .o_addr    (o_addr),
        .o_rd_we   (o_rd_we),
        .o_rd_addr (o_rd_addr),
        .o_rd_data (o_rd_data)
    );

    tb_rv_checker #(
        .p_max_events (max_events)
    ) checker_i (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_cyc         (o_cyc),
        .i_stb         (o_stb),
        .i_stall       (i_stall),
        .i_addr        (o_addr),
        .i_rd_we       (o_rd_we),
        .i_rd_addr     (o_rd_addr),
        .i_rd_data     (o_rd_data),
        .i_ev_is_write (ev_is_write),
        .i_ev_a        (ev_a),
        .i_ev_v        (ev_v),
        .i_ev_count    (ev_count),
        .o_done        (done),
        .o_seen_cnt    (seen_cnt),
        .o_pass_cnt    (pass_cnt),
        .o_fail_cnt    (fail_cnt)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] key;
        key = {addr[31:2], 2'b00};
        return mem.exists(key) ? mem[key] : 32'h0;
    endfunction

    task automatic load_cases();
        int fd;
        int n;
        string line;
        byte tag;
        logic [31:0] a;
        logic [31:0] v;
        fd = $fopen("rv_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open rv_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line[0] != "#") begin
                    v = '0;
                    n = $sscanf(line, "%c %h %h", tag, a, v);
                    if (tag == "m") begin
                        mem[a] = v;
                    end else if ((tag == "f" || tag == "w") && ev_count < max_events) begin
                        ev_is_write[ev_count] = (tag == "w");
                        ev_a[ev_count] = a;
                        ev_v[ev_count] = v;
                        ev_count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // idle slave holds stall high, so every strobe waits at least one cycle
    always @(posedge i_clk) begin
        if (i_rst) begin
            i_stall <= 1'b1;
            i_ack <= 1'b0;
            phase = 0;
        end else if (phase == 0) begin
            if (o_cyc && o_stb) begin
                req_addr = o_addr;
                rnd = xorshift32(rnd);
                stall_left = int'(rnd % 4);
                rnd = xorshift32(rnd);
                ack_left = int'(rnd % 4);
                phase = 1;
            end
        end else if (phase == 1) begin
            if (stall_left == 0) begin
                i_stall <= 1'b0;
                phase = 2;
            end else begin
                stall_left--;
            end
        end else if (phase == 2) begin
            if (ack_left == 0) begin
                i_ack <= 1'b1;
                i_data <= read_word(req_addr);
                phase = 3;
            end else begin
                ack_left--;
            end
        end else begin
            i_ack <= 1'b0;
            i_stall <= 1'b1;
            phase = 0;
        end
    end

    initial begin
        i_rst = 1'b1;
        i_ack = 1'b0;
        i_stall = 1'b1;
        i_data = 32'h0;
        load_cases();
        loaded = 1'b1;
        repeat (4) @(posedge i_clk);
        i_rst <= 1'b0;
        wait (done);
        @(posedge i_clk);
        $display("events %0d, passed %0d, failed %0d", ev_count, pass_cnt, fail_cnt);
        if (fail_cnt == 0 && ev_count > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog allows 40 cycles per expected event
    initial begin
        wait (loaded);
        #((ev_count + 1) * 40 * 100);
        $display("timeout: only %0d of %0d expected events were seen", seen_cnt, ev_count);
        $display("events %0d, passed %0d, failed %0d", ev_count, pass_cnt, fail_cnt);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* verilog.f */
rv_pkg.sv
rv_regfile.sv
rv_bus_master.sv
rv_sequencer.sv
rv_decoder.sv
rv_execute.sv
rv_core.sv
tb_rv_checker.sv
tb_rv_core.sv
